// File: source/dsp_pkg.sv
////////////////////////////////////////////////////////////
// Receive chain shared types and constants
////////////////////////////////////////////////////////////

package dsp_pkg;

   // Bits of one real sample on every link of the chain
   localparam int sample_width = 18;

   // Width of the shared multiplier product and of the accumulator
   localparam int acc_width = 36;

   // Width of the rounder result before it is clipped to a sample
   localparam int rnd_width = 19;

   // Half-band taps, impulse response [A 0 B 0.5 B 0 A]
   // Both taps are scaled by 2^18, so the centre tap of one half is 2^17
   // The outer tap is small and negative
   localparam logic signed [sample_width-1:0] coeff_a = -18'sd10690;

   // The inner tap carries most of the passband gain
   localparam logic signed [sample_width-1:0] coeff_b = 18'sd75809;

   // One sample on a strobed link
   // The sender raises stb for exactly one cycle and data is valid in that cycle
   // There is no ready signal, so a receiver takes every strobed word
   typedef struct packed {
      logic                           stb;
      logic signed [sample_width-1:0] data;
   } sample_t;

   // A sample_t is stb on top of the data word, 19 bits in all
   // Links are kept as whole structs so the strobe never drifts from its data

   // Rounding keeps the top rnd_width bits of the accumulator
   // The remaining acc_width - rnd_width bits are fed back as the residual

   // The chain is real only, with a single channel
   // Stage 1 runs at the input rate and stage 2 at half of it

endpackage

// File: source/round_sd.sv
////////////////////////////////////////////////////////////
// Sigma-delta rounding and clip
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module round_sd
(
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  strobe_in,
   input  logic signed [dsp_pkg::acc_width-1:0]  in,
   output logic                                  strobe_out,
   output logic signed [dsp_pkg::sample_width-1:0] out
);

   // Residual bits dropped by the rounding step, kept for the next strobe
   logic [dsp_pkg::acc_width-dsp_pkg::rnd_width-1:0] err;

   // Input plus the zero-extended residual of the previous strobed sum
   logic signed [dsp_pkg::acc_width-1:0] sum;

   // Rounded word, the top bits of the sum
   logic signed [dsp_pkg::rnd_width-1:0] rnd;

   // Rounded word clipped to the sample range
   logic signed [dsp_pkg::sample_width-1:0] sat;

   // Feeding the dropped bits back shapes the rounding error to high frequency
   // Over time the error averages out, so there is no DC bias
   assign sum = in + dsp_pkg::acc_width'(err);
   assign rnd = sum[dsp_pkg::acc_width-1 -: dsp_pkg::rnd_width];

   // The top two bits differ only when the value is out of sample range
   always_comb
   begin
      if (rnd[dsp_pkg::rnd_width-1] != rnd[dsp_pkg::rnd_width-2])
      begin
         // Clip towards the limit on the side of the sign
         sat = rnd[dsp_pkg::rnd_width-1] ?
               {1'b1, {(dsp_pkg::sample_width-1){1'b0}}} :
               {1'b0, {(dsp_pkg::sample_width-1){1'b1}}};
      end
      else
      begin
         sat = rnd[dsp_pkg::sample_width-1:0];
      end
   end

   // Error state and strobe are control, so they are cleared by reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         err        <= '0;
         strobe_out <= 1'b0;
      end
      else
      begin
         strobe_out <= strobe_in;
         // The residual only moves on a strobed sample
         if (strobe_in)
            err <= sum[dsp_pkg::acc_width-dsp_pkg::rnd_width-1:0];
      end
      // Result word, valid with strobe_out
      if (strobe_in)
         out <= sat;
   end

   // A rounded word leaves exactly one cycle after its input strobe
   assert property (@(posedge clk) disable iff (rst)
      1'b1 |=> (strobe_out == $past(strobe_in)))
      else $error("round_sd: strobe_out does not follow strobe_in by one cycle");

endmodule

// File: source/small_hb_dec.sv
////////////////////////////////////////////////////////////
// Seven-tap half-band decimate-by-two
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module small_hb_dec
(
   input  logic             clk,
   input  logic             rst,
   input  logic             run,
   input  logic             bypass,
   input  dsp_pkg::sample_t in,
   output dsp_pkg::sample_t out
);

   // Registered input sample
   dsp_pkg::sample_t in_d1;

   // Six older samples, dly[1] is the previous one and dly[6] the oldest
   logic signed [dsp_pkg::sample_width-1:0] dly [1:6];

   // Pair phase and the compute pulse pipeline
   logic phase;
   logic go;
   logic go_d1;
   logic go_d2;
   logic go_d3;
   logic go_d4;

   // Pre-added symmetric pairs and the centre sample, one bit of growth on the sums
   logic signed [dsp_pkg::sample_width:0]   outer_sum;
   logic signed [dsp_pkg::sample_width:0]   inner_sum;
   logic signed [dsp_pkg::sample_width-1:0] centre;
   logic signed [dsp_pkg::acc_width-1:0]    centre_ext;

   // Shared multiplier operands and its registered product
   logic signed [dsp_pkg::sample_width-1:0] mul_coeff;
   logic signed [dsp_pkg::sample_width:0]   mul_sum;
   logic signed [dsp_pkg::acc_width-1:0]    prod;

   logic signed [dsp_pkg::acc_width-1:0]    acc;

   // Rounded and clipped filter result
   logic                                    rnd_stb;
   logic signed [dsp_pkg::sample_width-1:0] rnd_data;

   always_ff @(posedge clk)
   begin
      if (rst)
         in_d1.stb <= 1'b0;
      else
         in_d1.stb <= in.stb;
      in_d1.data <= in.data;
   end

   // The delay line advances on every registered strobe, also while run is low
   // It is cleared by reset so the first outputs start from silence
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 1; i <= 6; i++)
            dly[i] <= '0;
      end
      else if (in_d1.stb)
      begin
         for (int i = 6; i > 1; i--)
            dly[i] <= dly[i-1];
         dly[1] <= in_d1.data;
      end
   end

   // Phase flips on each sample, so every second sample closes a pair
   // Clearing it with run makes the first sample after run the start of a pair
   always_ff @(posedge clk)
   begin
      if (rst || !run)
         phase <= 1'b0;
      else if (in_d1.stb)
         phase <= ~phase;
   end

   assign go = in_d1.stb & phase;

   // Pairs already started run to completion even when run drops
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         go_d1 <= 1'b0;
         go_d2 <= 1'b0;
         go_d3 <= 1'b0;
         go_d4 <= 1'b0;
      end
      else
      begin
         go_d1 <= go;
         go_d2 <= go_d1;
         go_d3 <= go_d2;
         go_d4 <= go_d3;
      end
   end

   // At go the newest sample is still in in_d1, so the window is in_d1 and dly
   always_ff @(posedge clk)
   begin
      if (go)
      begin
         outer_sum <= in_d1.data + dly[6];
         inner_sum <= dly[2] + dly[4];
         centre    <= dly[3];
      end
   end

   // First multiply cycle takes the outer pair, the second the inner pair
   assign mul_coeff = go_d1 ? dsp_pkg::coeff_a : dsp_pkg::coeff_b;
   assign mul_sum   = go_d1 ? outer_sum : inner_sum;

   always_ff @(posedge clk)
   begin
      if (go_d1 || go_d2)
         prod <= mul_coeff * mul_sum;
   end

   // Centre tap of one half is the sample shifted to the 2^17 tap scale
   assign centre_ext = centre;

   always_ff @(posedge clk)
   begin
      if (rst)
         acc <= '0;
      else if (go_d2)
         acc <= (centre_ext <<< (dsp_pkg::sample_width - 1)) + prod;
      else if (go_d3)
         acc <= acc + prod;
   end

   round_sd u_round
   (
      .clk        (clk),
      .rst        (rst),
      .strobe_in  (go_d4),
      .in         (acc),
      .strobe_out (rnd_stb),
      .out        (rnd_data)
   );

   // In bypass every registered input goes straight out, with no decimation
   always_ff @(posedge clk)
   begin
      if (rst)
         out.stb <= 1'b0;
      else if (bypass)
         out.stb <= in_d1.stb;
      else
         out.stb <= rnd_stb;
      if (bypass)
         out.data <= in_d1.data;
      else if (rnd_stb)
         out.data <= rnd_data;
   end

   // Phase keeps pairs at least two cycles apart, which the shared multiplier needs
   assert property (@(posedge clk) disable iff (rst) go |=> !go)
      else $error("small_hb_dec: go high in two consecutive cycles");

endmodule

// File: source/hb_dec_chain.sv
////////////////////////////////////////////////////////////
// Decimate-by-four receive chain
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hb_dec_chain
(
   input  logic             clk,
   input  logic             rst,
   input  logic             run,
   input  logic [1:0]       bypass,
   input  dsp_pkg::sample_t in,
   output dsp_pkg::sample_t out
);

   // Stage 1 output, at most one sample every second cycle while filtering
   dsp_pkg::sample_t mid;

   // First half-band, runs at the input rate
   // Bit 0 of bypass passes the input through unfiltered
   small_hb_dec u_stage1
   (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .bypass (bypass[0]),
      .in     (in),
      .out    (mid)
   );

   // Second half-band, fed straight from stage 1 with no buffering
   // It can take a sample every cycle, so stage 1 never has to wait
   // Bit 1 of bypass passes stage 1 output through unfiltered
   small_hb_dec u_stage2
   (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .bypass (bypass[1]),
      .in     (mid),
      .out    (out)
   );

   // Each filtering stage keeps one sample of every two
   // With both filtering, one output leaves for every four inputs
   // A stage in bypass keeps all samples and adds two cycles of latency

endmodule

// File: tests/hb_model.svh
////////////////////////////////////////////////////////////
// Half-band chain reference model
////////////////////////////////////////////////////////////

`ifndef HB_MODEL_SVH
`define HB_MODEL_SVH

// Sample history per stage, index 0 is the newest and index 6 the oldest
longint model_dly [0:1][0:6];
bit     model_phase [0:1];
// Low bits left over by the last rounding of each stage
longint model_err [0:1];
// Chain outputs that the DUT still owes, oldest first
longint exp_q [$];

// The accumulator is only acc_width bits wide, so large sums wrap around
function automatic longint wrap_acc(longint v);
   longint m;
   m = v & ((longint'(1) <<< dsp_pkg::acc_width) - 1);
   if (m >= (longint'(1) <<< (dsp_pkg::acc_width - 1)))
      m = m - (longint'(1) <<< dsp_pkg::acc_width);
   return m;
endfunction

// Pairing starts over, the next sample opens a new pair
function automatic void model_restart();
   model_phase[0] = 1'b0;
   model_phase[1] = 1'b0;
endfunction

function automatic void model_clear();
   for (int s = 0; s < 2; s++)
   begin
      for (int k = 0; k <= 6; k++)
         model_dly[s][k] = 0;
      model_err[s] = 0;
   end
   model_restart();
endfunction

// One strobed sample into stage s, returns 1 when the stage emits y
function automatic bit stage_push(int s, bit byp, bit run_on, longint x, output longint y);
   longint acc;
   longint sum;
   longint rnd;
   longint lim;
   bit     fired;
   lim = (longint'(1) <<< (dsp_pkg::sample_width - 1)) - 1;
   for (int k = 6; k > 0; k--)
      model_dly[s][k] = model_dly[s][k-1];
   model_dly[s][0] = x;
   fired = run_on && model_phase[s];
   y = 0;
   // The filter keeps running in bypass, so its rounding state moves on too
   if (fired)
   begin
      acc = longint'(dsp_pkg::coeff_a) * (model_dly[s][0] + model_dly[s][6])
          + longint'(dsp_pkg::coeff_b) * (model_dly[s][2] + model_dly[s][4])
          + model_dly[s][3] * (longint'(1) <<< (dsp_pkg::sample_width - 1));
      sum = wrap_acc(wrap_acc(acc) + model_err[s]);
      model_err[s] = sum & ((longint'(1) <<< (dsp_pkg::acc_width - dsp_pkg::rnd_width)) - 1);
      rnd = sum >>> (dsp_pkg::acc_width - dsp_pkg::rnd_width);
      y = (rnd > lim) ? lim : ((rnd < -lim - 1) ? -lim - 1 : rnd);
   end
   model_phase[s] = run_on && !model_phase[s];
   if (byp)
      y = x;
   return byp || fired;
endfunction

// Stage 1 output feeds stage 2, and whatever leaves stage 2 is queued
function automatic void chain_push(bit [1:0] byp, bit run_on, longint x);
   longint mid;
   longint y;
   bit     got;
   got = stage_push(0, byp[0], run_on, x, mid);
   if (got && stage_push(1, byp[1], run_on, mid, y))
      exp_q.push_back(y);
endfunction

`endif

// File: tests/tb_hb_dec_chain.sv
////////////////////////////////////////////////////////////
// Decimate-by-four chain testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_hb_dec_chain;

   logic             clk;
   logic             rst;
   logic             run;
   logic [1:0]       bypass;
   dsp_pkg::sample_t in;
   dsp_pkg::sample_t out;
   int unsigned      lcg_state;
   int               out_count;
   int               sat_count;

   `include "hb_model.svh"

   hb_dec_chain u_hb_dec_chain
      (.clk(clk), .rst(rst), .run(run), .bypass(bypass), .in(in), .out(out));

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic stop_with_failure(string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic compare_value(string name, longint got, longint expected);
      if (got !== expected)
         stop_with_failure($sformatf("error at %0t: %s is %0d, expected %0d",
                                     $time, name, got, expected));
   endtask

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Stimulus word for one pattern, i counts the samples of the block
   // Pattern 3 is a square wave of period 6 that drives some outputs past the limits
   function automatic logic signed [dsp_pkg::sample_width-1:0] sample_for(int mode, int i);
      case (mode)
         1: return (i % 2 != 0) ? -18'sd131072 : 18'sd131071;
         2: return 18'sd131071;
         3: return ((i / 3) % 2 != 0) ? -18'sd90000 : 18'sd90000;
         4: return (i == 1) ? 18'sd100000 : 18'sd0;
         default: return 18'(lcg_next() >> 14);
      endcase
   endfunction

   // Inputs change 1 ns after the edge, and every strobed word also goes to the model
   task automatic drive(bit stb, logic signed [dsp_pkg::sample_width-1:0] x);
      @(posedge clk);
      #1;
      in.stb  = stb;
      in.data = x;
      if (stb)
         chain_push(bypass, run, x);
   endtask

   // Outputs are registers, so they are settled by the falling edge
   always @(negedge clk)
   begin
      if (!rst && out.stb === 1'b1)
      begin
         if (exp_q.size() == 0)
            stop_with_failure("an output appeared while no output was expected");
         else
            compare_value("out.data", out.data, exp_q.pop_front());
         out_count++;
         if (out.data == 18'sd131071 || out.data == -18'sd131072)
            sat_count++;
      end
   end

   task automatic drain();
      int waited;
      waited = 0;
      drive(1'b0, '0);
      while (exp_q.size() != 0)
      begin
         @(posedge clk);
         waited++;
         if (waited > 500)
            stop_with_failure("timeout while waiting for the expected outputs");
      end
      // Quiet time in which a stray extra output would still be caught
      repeat (20) drive(1'b0, '0);
   endtask

   task automatic restart();
      drive(1'b0, '0);
      run = 1'b0;
      repeat (3) drive(1'b0, '0);
      model_restart();
      run = 1'b1;
   endtask

   // n samples with strobes in about density percent of the cycles
   task automatic run_block(int n, int density, int mode);
      int sent;
      int start;
      restart();
      start = out_count;
      sent  = 0;
      while (sent < n)
      begin
         if ((lcg_next() >> 16) % 100 < density)
         begin
            drive(1'b1, sample_for(mode, sent));
            sent++;
         end
         else
            drive(1'b0, '0);
      end
      drain();
      // Each filtering stage halves the count
      compare_value("output count", out_count - start,
                    n >> ((bypass[0] ? 0 : 1) + (bypass[1] ? 0 : 1)));
   endtask

   initial
   begin
      int start;
      lcg_state = 85;
      rst = 1'b1;
      run = 1'b0;
      bypass = 2'b00;
      in = '0;
      out_count = 0;
      sat_count = 0;
      model_clear();
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      // Impulse on the second sample of a pair, first with stage 2 in bypass
      bypass = 2'b10;
      run_block(12, 100, 4);
      bypass = 2'b00;
      run_block(12, 100, 4);
      run_block(400, 100, 0);
      for (int b = 0; b < 4; b++)
      begin
         bypass = 2'(b);
         run_block(200, 60, 0);
      end
      start = sat_count;
      for (int b = 0; b < 4; b += 2)
      begin
         bypass = 2'(b);
         for (int m = 1; m <= 3; m++)
            run_block(48, 100, m);
      end
      if (sat_count == start)
         stop_with_failure("no output reached the sample limits in the full-scale test");
      // Odd block leaves stage 1 halfway through a pair when run drops
      bypass = 2'b00;
      run_block(101, 100, 0);
      start = out_count;
      run = 1'b0;
      repeat (2) drive(1'b0, '0);
      repeat (9) drive(1'b1, sample_for(0, 0));
      drain();
      compare_value("output count while run low", out_count - start, 0);
      run_block(200, 100, 0);
      if (exp_q.size() != 0)
         stop_with_failure("expected outputs were left over at the end of the run");
      else
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

// File: list.f
+incdir+tests
source/dsp_pkg.sv
source/round_sd.sv
source/small_hb_dec.sv
source/hb_dec_chain.sv
tests/tb_hb_dec_chain.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = tb_hb_dec_chain
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
